// ==== verilog/hs_ad_da_pkg.sv ====
/* AD/DA loop shared definitions
   Register map, field widths, config and statistics structs */
`default_nettype none

package hs_ad_da_pkg;

    // ------------------------------
    // Data path widths
    // ------------------------------
    localparam int sample_w   = 8;
    localparam int addr_w     = 8;
    localparam int rom_depth  = 256;
    localparam int otr_cnt_w  = 16;
    localparam int div_w      = 8;
    localparam int step_w     = addr_w;

    // ------------------------------
    // APB bus and register map
    // ------------------------------
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    localparam logic [apb_addr_w-1:0] reg_ctrl   = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_step   = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_div    = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_last   = 8'h0C;
    localparam logic [apb_addr_w-1:0] reg_minmax = 8'h10;
    localparam logic [apb_addr_w-1:0] reg_otr    = 8'h14;

    // Bit positions in reg_ctrl
    localparam int ctrl_da_en_bit = 0;
    localparam int ctrl_ad_en_bit = 1;
    localparam int ctrl_clr_bit   = 2;

    // Configuration from the register file, 26 bits
    typedef struct packed {
        logic              da_en;
        logic              ad_en;
        logic [step_w-1:0] da_step;
        logic [div_w-1:0]  da_div;
        logic [div_w-1:0]  ad_div;
    } ctrl_cfg_t;

    // Capture statistics, 40 bits
    typedef struct packed {
        logic [sample_w-1:0]  last;
        logic [sample_w-1:0]  min_val;
        logic [sample_w-1:0]  max_val;
        logic [otr_cnt_w-1:0] otr_cnt;
    } ad_stat_t;

    // APB slave states
    typedef enum logic [1:0] {
        idle,
        access,
        done
    } apb_state_t;

endpackage

`default_nettype wire

// ==== verilog/wave_rom.sv ====
/* Waveform ROM, 256 x 8, synchronous read
   Holds a triangle table computed when the design is built */
`timescale 1ns/1ps
`default_nettype none

module wave_rom (
    input  wire                               sys_clk,
    input  wire [hs_ad_da_pkg::addr_w-1:0]    rom_addr,
    output logic [hs_ad_da_pkg::sample_w-1:0] rom_data
);
    import hs_ad_da_pkg::*;

    // Table storage
    logic [sample_w-1:0] rom_mem [rom_depth];

    // Triangle rule
    // rising half 2a, falling half 2(depth-1-a)+1, all values distinct
    function automatic int unsigned tri_value(input int unsigned a, input int unsigned depth);
        if (a < depth / 2) begin
            return 2 * a;
        end
        return 2 * (depth - 1 - a) + 1;
    endfunction

    // ------------------------------
    // Table fill
    // ------------------------------
    initial begin
        for (int a = 0; a < rom_depth; a++) begin
            rom_mem[a] = sample_w'(tri_value(a, rom_depth));
        end
    end

    // ------------------------------
    // Registered read port
    // ------------------------------
    // One cycle latency from address to data
    always_ff @(posedge sys_clk) begin
        rom_data <= rom_mem[rom_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/sample_timer.sv ====
/* Sample tick generator
   Divides sys_clk into DAC and ADC sample ticks, flags the ADC clock midpoint */
`timescale 1ns/1ps
`default_nettype none

module sample_timer (
    input  wire                      sys_clk,
    input  wire                      arst_n,
    input  wire hs_ad_da_pkg::ctrl_cfg_t cfg,
    output logic                     da_tick,
    output logic                     ad_tick,
    output logic                     ad_half
);
    import hs_ad_da_pkg::*;

    // Channel 0 is DAC, channel 1 is ADC
    logic             ch_en   [2];
    logic [div_w-1:0] ch_div  [2];
    logic [div_w-1:0] ch_cnt  [2];
    logic             ch_run  [2];
    logic             ch_tick [2];
    // ADC high phase length and the count value where it ends
    logic [div_w-1:0] ad_hi_len;
    logic [div_w-1:0] ad_mid;

    assign ch_en[0]  = cfg.da_en;
    assign ch_en[1]  = cfg.ad_en;
    assign ch_div[0] = cfg.da_div;
    assign ch_div[1] = cfg.ad_div;

    // ------------------------------
    // Down-counters
    // ------------------------------
    for (genvar i = 0; i < 2; i++) begin : g_ch
        // Held at zero while off
        // first enabled cycle reloads, so first tick lands div+1 cycles later
        always_ff @(posedge sys_clk or negedge arst_n) begin
            if (!arst_n) begin
                ch_cnt[i] <= '0;
                ch_run[i] <= 1'b0;
            end else if (!ch_en[i]) begin
                ch_cnt[i] <= '0;
                ch_run[i] <= 1'b0;
            end else begin
                ch_run[i] <= 1'b1;
                if (ch_cnt[i] == '0) begin
                    ch_cnt[i] <= ch_div[i];
                end else begin
                    ch_cnt[i] <= ch_cnt[i] - 1'b1;
                end
            end
        end

        // Tick on terminal count once running
        assign ch_tick[i] = ch_en[i] && ch_run[i] && (ch_cnt[i] == '0);
    end

    assign da_tick = ch_tick[0];
    assign ad_tick = ch_tick[1];

    // ------------------------------
    // ADC clock midpoint
    // ------------------------------
    // High for half the period, rounded down, at least one cycle
    assign ad_hi_len = (cfg.ad_div == '0) ? div_w'(1)
                                           : div_w'(((div_w+1)'(cfg.ad_div) + 1'b1) >> 1);
    // Count value seen in the last high cycle
    assign ad_mid    = cfg.ad_div - ad_hi_len + div_w'(1);
    assign ad_half   = ch_en[1] && ch_run[1] && (ch_cnt[1] == ad_mid);

endmodule

`default_nettype wire

// ==== verilog/da_wave_send.sv ====
/* DAC waveform sender
   Steps the ROM phase address and drives DAC data with its sample clock */
`timescale 1ns/1ps
`default_nettype none

module da_wave_send (
    input  wire                               sys_clk,
    input  wire                               arst_n,
    input  wire                               da_en,
    input  wire [hs_ad_da_pkg::step_w-1:0]    da_step,
    input  wire                               da_tick,
    output logic [hs_ad_da_pkg::addr_w-1:0]   rom_addr,
    input  wire [hs_ad_da_pkg::sample_w-1:0]  rom_data,
    output logic                              da_clk,
    output logic [hs_ad_da_pkg::sample_w-1:0] da_data
);
    import hs_ad_da_pkg::*;

    // Phase accumulator, wraps mod 256
    logic [addr_w-1:0] phase;
    // Tick delayed to line up with ROM output
    logic              tick_d;

    // Current phase goes straight to the ROM
    assign rom_addr = phase;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= '0;
            tick_d  <= 1'b0;
            da_clk  <= 1'b0;
            da_data <= '0;
        end else begin
            tick_d <= da_tick;
            // One-cycle strobe, same cycle as new data
            da_clk <= tick_d;
            if (tick_d) begin
                da_data <= rom_data;
            end
            // Restart at address 0 when disabled
            if (!da_en) begin
                phase <= '0;
            end else if (da_tick) begin
                phase <= phase + da_step;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ad_wave_rec.sv ====
/* ADC sample receiver
   Drives the ADC clock, captures samples and keeps last/min/max/out-of-range stats */
`timescale 1ns/1ps
`default_nettype none

module ad_wave_rec (
    input  wire                              sys_clk,
    input  wire                              arst_n,
    input  wire                              ad_tick,
    input  wire                              ad_half,
    input  wire                              stat_clr,
    input  wire [hs_ad_da_pkg::sample_w-1:0] ad_data,
    input  wire                              ad_otr,
    output logic                             ad_clk,
    output hs_ad_da_pkg::ad_stat_t           stat
);
    import hs_ad_da_pkg::*;

    // ------------------------------
    // ADC clock
    // ------------------------------
    // Rises on tick, falls at midpoint
    // tick wins when both coincide, i.e. divider of zero
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            ad_clk <= 1'b0;
        end else if (ad_tick) begin
            ad_clk <= 1'b1;
        end else if (ad_half) begin
            ad_clk <= 1'b0;
        end
    end

    // ------------------------------
    // Capture and statistics
    // ------------------------------
    // Same edge that raises ad_clk samples the bus
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            stat.last    <= '0;
            stat.min_val <= '1;
            stat.max_val <= '0;
            stat.otr_cnt <= '0;
        end else begin
            // Last value survives a clear
            if (ad_tick) begin
                stat.last <= ad_data;
            end
            if (stat_clr) begin
                stat.min_val <= '1;
                stat.max_val <= '0;
                stat.otr_cnt <= '0;
            end else if (ad_tick) begin
                // Running extremes
                if (ad_data < stat.min_val) begin
                    stat.min_val <= ad_data;
                end
                if (ad_data > stat.max_val) begin
                    stat.max_val <= ad_data;
                end
                // Saturating out-of-range count
                if (ad_otr && (stat.otr_cnt != '1)) begin
                    stat.otr_cnt <= stat.otr_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/apb_ctrl_fsm.sv ====
/* APB slave for the AD/DA loop
   One wait state per access, config registers, clear pulse and stats readback */
`timescale 1ns/1ps
`default_nettype none

module apb_ctrl_fsm (
    input  wire                                 sys_clk,
    input  wire                                 arst_n,
    input  wire [hs_ad_da_pkg::apb_addr_w-1:0]  paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire [hs_ad_da_pkg::apb_data_w-1:0]  pwdata,
    output logic [hs_ad_da_pkg::apb_data_w-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output hs_ad_da_pkg::ctrl_cfg_t             cfg,
    output logic                                stat_clr,
    input  wire hs_ad_da_pkg::ad_stat_t         stat
);
    import hs_ad_da_pkg::*;

    apb_state_t            state;
    logic [apb_data_w-1:0] rd_word;
    logic                  addr_err;
    logic                  ro_hit;
    logic                  acc_err;
    logic                  acc_start;

    // First access cycle
    assign acc_start = (state == idle) && psel && penable;

    // ------------------------------
    // Address decode and read mux
    // ------------------------------
    always_comb begin
        rd_word  = '0;
        addr_err = 1'b0;
        ro_hit   = 1'b0;
        case (paddr)
            reg_ctrl: begin
                // Clear bit always reads back as zero
                rd_word[ctrl_da_en_bit] = cfg.da_en;
                rd_word[ctrl_ad_en_bit] = cfg.ad_en;
            end
            reg_step: rd_word[step_w-1:0] = cfg.da_step;
            reg_div:  rd_word[2*div_w-1:0] = {cfg.ad_div, cfg.da_div};
            reg_last: begin
                rd_word[sample_w-1:0] = stat.last;
                ro_hit                = 1'b1;
            end
            reg_minmax: begin
                rd_word[2*sample_w-1:0] = {stat.max_val, stat.min_val};
                ro_hit                  = 1'b1;
            end
            reg_otr: begin
                rd_word[otr_cnt_w-1:0] = stat.otr_cnt;
                ro_hit                 = 1'b1;
            end
            default: addr_err = 1'b1;
        endcase
    end

    // Unmapped, or write to a status register
    assign acc_err = addr_err || (pwrite && ro_hit);

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    // idle sees first access cycle, access drives pready, done lets the bus settle
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= idle;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (acc_start) begin
                        state   <= access;
                        pready  <= 1'b1;
                        pslverr <= acc_err;
                    end
                end
                access: begin
                    state   <= done;
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                end
                done:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Stats snapshot from first access cycle
    always_ff @(posedge sys_clk) begin
        if (acc_start) begin
            prdata <= rd_word;
        end
    end

    // ------------------------------
    // Config register file
    // ------------------------------
    // Written at the end of the pready cycle
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg      <= '0;
            stat_clr <= 1'b0;
        end else begin
            stat_clr <= 1'b0;
            if ((state == access) && pwrite && !pslverr) begin
                case (paddr)
                    reg_ctrl: begin
                        cfg.da_en <= pwdata[ctrl_da_en_bit];
                        cfg.ad_en <= pwdata[ctrl_ad_en_bit];
                        stat_clr  <= pwdata[ctrl_clr_bit];
                    end
                    reg_step: cfg.da_step <= pwdata[step_w-1:0];
                    reg_div: begin
                        cfg.da_div <= pwdata[div_w-1:0];
                        cfg.ad_div <= pwdata[2*div_w-1:div_w];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hs_ad_da.sv ====
/* High-speed AD/DA loop top level
   APB control, sample timer, waveform ROM, DAC sender and ADC receiver */
`timescale 1ns/1ps
`default_nettype none

module hs_ad_da (
    input  wire                                 sys_clk,
    input  wire                                 arst_n,
    // APB slave
    input  wire [hs_ad_da_pkg::apb_addr_w-1:0]  paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire [hs_ad_da_pkg::apb_data_w-1:0]  pwdata,
    output logic [hs_ad_da_pkg::apb_data_w-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    // DAC pins
    output logic                                da_clk,
    output logic [hs_ad_da_pkg::sample_w-1:0]   da_data,
    // ADC pins, otr high means input out of range
    input  wire [hs_ad_da_pkg::sample_w-1:0]    ad_data,
    input  wire                                 ad_otr,
    output logic                                ad_clk
);
    import hs_ad_da_pkg::*;

    ctrl_cfg_t           cfg;
    ad_stat_t            stat;
    logic                stat_clr;
    logic                da_tick;
    logic                ad_tick;
    logic                ad_half;
    logic [addr_w-1:0]   rom_addr;
    logic [sample_w-1:0] rom_data;

    // Register access
    apb_ctrl_fsm u_apb_ctrl_fsm (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cfg      (cfg),
        .stat_clr (stat_clr),
        .stat     (stat)
    );

    // Sample rate dividers
    sample_timer u_sample_timer (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .cfg     (cfg),
        .da_tick (da_tick),
        .ad_tick (ad_tick),
        .ad_half (ad_half)
    );

    // Triangle table
    wave_rom u_wave_rom (
        .sys_clk  (sys_clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    // DAC output path
    da_wave_send u_da_wave_send (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .da_en    (cfg.da_en),
        .da_step  (cfg.da_step),
        .da_tick  (da_tick),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .da_clk   (da_clk),
        .da_data  (da_data)
    );

    // ADC capture path
    ad_wave_rec u_ad_wave_rec (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .ad_tick  (ad_tick),
        .ad_half  (ad_half),
        .stat_clr (stat_clr),
        .ad_data  (ad_data),
        .ad_otr   (ad_otr),
        .ad_clk   (ad_clk),
        .stat     (stat)
    );

endmodule

`default_nettype wire

// ==== test/tb_hs_ad_da.sv ====
/* Testbench for the AD/DA loop
   Random APB traffic and ADC input, checked against a triangle and statistics model */
`timescale 1ns/1ps
`default_nettype none

module tb_hs_ad_da;
    import hs_ad_da_pkg::*;

    localparam int apb_limit   = 20;
    localparam int pulse_limit = 5000;

    logic        sys_clk;
    logic        arst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        da_clk;
    logic [7:0]  da_data;
    logic [7:0]  ad_data;
    logic        ad_otr;
    logic        ad_clk;

    // Error counts
    int          err_cnt = 0;
    int          tmo_cnt = 0;
    // Random state for the main flow and the ADC pins
    logic [31:0] rnd;
    logic [31:0] pin_rnd;
    // DAC model
    logic [7:0]  dac_addr = '0;
    logic [7:0]  dac_step = '0;
    int          dac_div = 0;
    bit          dac_have_prev = 1'b0;
    int          dac_last_cyc = 0;
    int          dac_pulses = 0;
    int          cyc = 0;
    // ADC model
    logic [7:0]  edge_data;
    logic        edge_otr;
    logic        ad_clk_q = 1'b0;
    int          adc_caps = 0;
    int          ad_hi_cyc = 0;
    int          adc_hi_exp = 1;
    logic [7:0]  m_last = 8'd0;
    logic [7:0]  m_min = 8'd255;
    logic [7:0]  m_max = 8'd0;
    int          m_otr = 0;

    hs_ad_da u_hs_ad_da (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .da_clk  (da_clk),
        .da_data (da_data),
        .ad_data (ad_data),
        .ad_otr  (ad_otr),
        .ad_clk  (ad_clk)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Triangle rule
    // 2a on the rising half, 2(255-a)+1 on the falling half
    function automatic logic [7:0] tri_ref(input logic [7:0] a);
        if (a < 8'd128) begin
            return 8'(2 * int'(a));
        end
        return 8'(2 * (255 - int'(a)) + 1);
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("CHECK FAILED @ %0t ns: %s", $time, msg);
    endtask

    task automatic end_run;
        $display("Result: %0d check errors, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        tmo_cnt++;
        $display("TIMEOUT @ %0t ns: %s", $time, msg);
        end_run();
    endtask

    // Setup cycle, access cycle, then hold until pready
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int n;
        @(posedge sys_clk);
        #1;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge sys_clk);
        #1;
        penable = 1'b1;
        n = 0;
        while (!pready) begin
            if (n == apb_limit) begin
                abort_run($sformatf("pready never came for APB access to 0x%02h", addr));
            end
            @(posedge sys_clk);
            #1;
            n++;
        end
        rdata = prdata;
        err   = pslverr;
        // Transfer completes on the edge that ends the pready cycle
        @(posedge sys_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_pulses(input bit on_adc, input int target);
        int n;
        n = 0;
        while ((on_adc ? adc_caps : dac_pulses) < target) begin
            if (n == pulse_limit) begin
                abort_run($sformatf("%s pulses stopped before count %0d",
                                    on_adc ? "ad_clk" : "da_clk", target));
            end
            @(posedge sys_clk);
            n++;
        end
    endtask

    // ------------------------------
    // Pin stimulus and monitors
    // ------------------------------
    initial begin
        ad_data = '0;
        ad_otr  = 1'b0;
        pin_rnd = 32'd12;
        forever begin
            @(posedge sys_clk);
            #1;
            pin_rnd = xorshift32(pin_rnd);
            ad_data = pin_rnd[7:0];
            ad_otr  = pin_rnd[8];
        end
    end

    // ADC pins as seen by the DUT at each edge
    always @(posedge sys_clk) begin
        edge_data <= ad_data;
        edge_otr  <= ad_otr;
    end

    // DAC pulses checked mid-cycle
    always @(negedge sys_clk) begin
        cyc = cyc + 1;
        if (arst_n && da_clk) begin
            if (da_data !== tri_ref(dac_addr)) begin
                report_error($sformatf("da_data %0d, expected %0d for address %0d",
                                       da_data, tri_ref(dac_addr), dac_addr));
            end
            if (dac_have_prev && (cyc - dac_last_cyc != dac_div + 1)) begin
                report_error($sformatf("da_clk spacing %0d, expected %0d",
                                       cyc - dac_last_cyc, dac_div + 1));
            end
            dac_have_prev = 1'b1;
            dac_last_cyc  = cyc;
            dac_addr      = dac_addr + dac_step;
            dac_pulses++;
        end
    end

    // Statistics model updated on each rising ad_clk
    always @(negedge sys_clk) begin
        if (arst_n && ad_clk && !ad_clk_q) begin
            m_last = edge_data;
            if (edge_data < m_min) begin
                m_min = edge_data;
            end
            if (edge_data > m_max) begin
                m_max = edge_data;
            end
            if (edge_otr && m_otr < 65535) begin
                m_otr++;
            end
            adc_caps++;
        end
        // High phase length, checked when ad_clk falls
        if (arst_n && ad_clk) begin
            ad_hi_cyc++;
        end else if (arst_n && ad_clk_q) begin
            if (ad_hi_cyc != adc_hi_exp) begin
                report_error($sformatf("ad_clk high for %0d cycles, expected %0d",
                                       ad_hi_cyc, adc_hi_exp));
            end
            ad_hi_cyc = 0;
        end
        ad_clk_q = ad_clk;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] exp_val;
        logic        err;
        logic [31:0] step_val;
        logic [31:0] div_val;
        int          ad_div_i;
        int          settle;
        int          snap_da;
        int          snap_ad;
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        rnd     = 32'd12;
        repeat (2) @(posedge sys_clk);
        #1;
        arst_n = 1'b1;

        // Reset state
        @(negedge sys_clk);
        if (da_clk !== 1'b0 || ad_clk !== 1'b0 || pready !== 1'b0 || pslverr !== 1'b0) begin
            report_error("pins not low after reset");
        end
        if (da_data !== 8'd0) begin
            report_error($sformatf("da_data %0d after reset", da_data));
        end
        for (int a = 0; a <= 'h14; a += 4) begin
            apb_read(8'(a), rd, err);
            exp_val = (8'(a) == reg_minmax) ? 32'h0000_00ff : 32'h0;
            if (rd !== exp_val || err !== 1'b0) begin
                report_error($sformatf("reset read 0x%02h gave 0x%08h err %b", a, rd, err));
            end
        end

        // Register readback
        rnd = xorshift32(rnd);
        step_val = rnd;
        apb_write(reg_step, step_val, err);
        apb_read(reg_step, rd, err);
        if (rd !== (step_val & 32'hff)) begin
            report_error($sformatf("reg_step read 0x%08h after write 0x%08h", rd, step_val));
        end
        rnd = xorshift32(rnd);
        div_val = rnd;
        apb_write(reg_div, div_val, err);
        apb_read(reg_div, rd, err);
        if (rd !== (div_val & 32'hffff)) begin
            report_error($sformatf("reg_div read 0x%08h after write 0x%08h", rd, div_val));
        end
        apb_write(reg_ctrl, 32'h4, err);
        apb_read(reg_ctrl, rd, err);
        if (rd !== 32'h0) begin
            report_error($sformatf("reg_ctrl read 0x%08h, clear bit must read zero", rd));
        end

        // Bus errors leave everything unchanged
        apb_write(8'h40, 32'hdead_beef, err);
        if (err !== 1'b1) begin
            report_error("write to unmapped address without pslverr");
        end
        apb_read(8'h40, rd, err);
        if (err !== 1'b1) begin
            report_error("read of unmapped address without pslverr");
        end
        apb_write(reg_last, 32'hab, err);
        if (err !== 1'b1) begin
            report_error("write to reg_last without pslverr");
        end
        apb_read(reg_ctrl, rd, err);
        if (rd !== 32'h0) begin
            report_error($sformatf("reg_ctrl changed to 0x%08h by bad access", rd));
        end
        apb_read(reg_step, rd, err);
        if (rd !== (step_val & 32'hff)) begin
            report_error($sformatf("reg_step changed to 0x%08h by bad access", rd));
        end
        apb_read(reg_div, rd, err);
        if (rd !== (div_val & 32'hffff)) begin
            report_error($sformatf("reg_div changed to 0x%08h by bad access", rd));
        end
        apb_read(reg_last, rd, err);
        if (rd !== 32'h0) begin
            report_error($sformatf("reg_last changed to 0x%08h by bad write", rd));
        end

        // DAC waveform with random step and divider
        rnd = xorshift32(rnd);
        dac_step = rnd[7:0];
        dac_div  = int'(rnd[11:8]);
        ad_div_i = 1 + int'(rnd[15:12]) % 15;
        // High phase is half the ADC period, rounded down
        adc_hi_exp = (ad_div_i + 1) / 2;
        apb_write(reg_step, {24'h0, dac_step}, err);
        apb_write(reg_div, {16'h0, 8'(ad_div_i), 8'(dac_div)}, err);
        dac_addr      = '0;
        dac_have_prev = 1'b0;
        apb_write(reg_ctrl, 32'h1, err);
        wait_pulses(1'b0, 30);

        // ADC capture alongside the running DAC
        apb_write(reg_ctrl, 32'h3, err);
        apb_read(reg_ctrl, rd, err);
        if (rd !== 32'h3) begin
            report_error($sformatf("reg_ctrl read 0x%08h with both enables set", rd));
        end
        wait_pulses(1'b1, 25);

        // Disable both and expect no more pulses
        apb_write(reg_ctrl, 32'h0, err);
        settle = ((dac_div > ad_div_i) ? dac_div : ad_div_i) + 4;
        repeat (settle) @(posedge sys_clk);
        snap_da = dac_pulses;
        snap_ad = adc_caps;
        repeat (2 * settle) @(posedge sys_clk);
        if (dac_pulses != snap_da || adc_caps != snap_ad) begin
            report_error("da_clk or ad_clk still pulsing after disable");
        end
        apb_read(reg_last, rd, err);
        if (rd !== {24'h0, m_last}) begin
            report_error($sformatf("reg_last 0x%08h, expected 0x%02h", rd, m_last));
        end
        apb_read(reg_minmax, rd, err);
        if (rd !== {16'h0, m_max, m_min}) begin
            report_error($sformatf("reg_minmax 0x%08h, expected max %0d min %0d", rd, m_max, m_min));
        end
        apb_read(reg_otr, rd, err);
        if (rd !== 32'(m_otr)) begin
            report_error($sformatf("reg_otr %0d, expected %0d", rd, m_otr));
        end

        // Clear statistics but keep the last value
        apb_write(reg_ctrl, 32'h4, err);
        m_min = 8'd255;
        m_max = 8'd0;
        m_otr = 0;
        apb_read(reg_minmax, rd, err);
        if (rd !== 32'h0000_00ff) begin
            report_error($sformatf("reg_minmax 0x%08h after clear", rd));
        end
        apb_read(reg_otr, rd, err);
        if (rd !== 32'h0) begin
            report_error($sformatf("reg_otr %0d after clear", rd));
        end
        apb_read(reg_last, rd, err);
        if (rd !== {24'h0, m_last}) begin
            report_error($sformatf("reg_last 0x%08h after clear, expected 0x%02h", rd, m_last));
        end

        // DAC restarts at address 0
        dac_addr      = '0;
        dac_have_prev = 1'b0;
        apb_write(reg_ctrl, 32'h1, err);
        wait_pulses(1'b0, dac_pulses + 12);
        end_run();
    end

endmodule

`default_nettype wire

// ==== hs_ad_da.f ====
verilog/hs_ad_da_pkg.sv
verilog/wave_rom.sv
verilog/sample_timer.sv
verilog/da_wave_send.sv
verilog/ad_wave_rec.sv
verilog/apb_ctrl_fsm.sv
verilog/hs_ad_da.sv
test/tb_hs_ad_da.sv

// ==== Makefile ====
# Verilator flow for the AD/DA loop
# lint checks the RTL top, sim builds and runs the testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module hs_ad_da -f hs_ad_da.f

sim:
	verilator --binary --timing -j 0 --top-module tb_hs_ad_da -Mdir obj_dir -f hs_ad_da.f
	./obj_dir/Vtb_hs_ad_da | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
